/* hdl/ex2_params.svh */
/* Widths, register IDs and stall lengths for the EX2 stage.
   Included by each RTL file that needs them. */

`ifndef EX2_PARAMS_SVH
`define EX2_PARAMS_SVH

// Datapath widths
`define EX2_XLEN      64
`define EX2_TAGGED_W  66	// Value plus 2-bit tag
`define EX2_GPR_ID_W  6
`define EX2_CR_ID_W   5

// Micro-op fields
`define EX2_UCMD_W    8	// Predicate bits over a 6-bit command
`define EX2_UIXT_W    6

// Register IDs
`define EX2_GR_NONE   6'd0	// No GPR write
`define EX2_GR_DLR    6'd33
`define EX2_CR_NONE   5'd31	// No CR write
`define EX2_CR_KRR    5'd8	// Keyring register

// Hold cycles per operation class
`define EX2_HOLD_W     4
`define EX2_HOLD_SLEEP 4'd15
`define EX2_HOLD_MUL   4'd3
`define EX2_HOLD_MEM   4'd1	// Memory always waits one cycle
`define EX2_HOLD_MAX   4'd15	// Counter saturates here

`endif

/* hdl/ex2Pkg.sv */
/* Shared enum types for the EX2 stage: micro-op commands, IXT sub-ops,
   predicate modes and L1 data status. Referenced by scoped name only. */

package ex2Pkg;

	// Micro-op command, low six bits of opUCmd
	typedef enum logic [5:0] {
		ucNop    = 6'h00,	// No operation
		ucOpIxt  = 6'h01,	// Extended op, sub-op in opUIxt
		ucMovMr  = 6'h02,	// Load, memory to register
		ucMovRm  = 6'h03,	// Store, register to memory
		ucAlu3   = 6'h04,	// Three-operand ALU
		ucUnary  = 6'h05,	// Single-operand ALU
		ucAluw3  = 6'h06,	// Packed word ALU
		ucAluCmp = 6'h07,	// Compare, status only
		ucMul3   = 6'h08,	// Multi-cycle multiply
		ucMulw3  = 6'h09,	// Word multiply
		ucFpu3   = 6'h0A,	// FPU op with GPR result
		ucFcmp   = 6'h0B,	// FPU compare
		ucBra    = 6'h0C	// Branch, resolved in EX1
	} uCmd;

	// IXT sub-ops
	typedef enum logic [5:0] {
		ixNop    = 6'h00,
		ixSleep  = 6'h01,	// Long fixed stall
		ixLdeKrr = 6'h02,	// Keyring load, tag checked
		ixLdeEnc = 6'h03	// Keyring encode into DLR
	} ixtOp;

	// Predicate mode, top two bits of opUCmd
	typedef enum logic [1:0] {
		predAlways  = 2'b00,
		predNever   = 2'b01,
		predIfTrue  = 2'b10,	// Run if T set
		predIfFalse = 2'b11	// Run if T clear
	} predMode;

	// L1 data port status, bit 1 means not ready
	typedef enum logic [1:0] {
		msOk    = 2'b01,
		msHold  = 2'b10,
		msFault = 2'b11
	} memStatus;

endpackage

/* hdl/ex2Writeback.sv */
/* EX2 result selection: picks the GPR/CR destination and the new status
   register for the effective command. Purely combinational. */

`include "ex2_params.svh"

module ex2Writeback (
	input  ex2Pkg::uCmd                cmd,		// Effective command, nop when disabled
	input  ex2Pkg::ixtOp               ixt,		// Sub-op for opIxt
	input  logic [`EX2_GPR_ID_W-1:0]   regIdRm,		// Instruction destination
	input  logic [`EX2_GPR_ID_W-1:0]   regIdRn1,	// EX1 GPR destination
	input  logic [`EX2_XLEN-1:0]       regValRn1,
	input  logic [`EX2_CR_ID_W-1:0]    regIdCn1,	// EX1 CR destination
	input  logic [`EX2_XLEN-1:0]       regValCn1,
	input  logic [`EX2_TAGGED_W-1:0]   aluRes,		// ALU value and T/S tag
	input  logic [`EX2_XLEN-1:0]       mulRes,
	input  logic [`EX2_XLEN-1:0]       mulwRes,
	input  logic [`EX2_TAGGED_W-1:0]   krreRes,		// Keyring value and tag
	input  logic [`EX2_XLEN-1:0]       fpuRes,
	input  logic                       fpuSrT,		// FPU compare result
	input  logic [`EX2_XLEN-1:0]       memData,		// L1 load data
	input  logic [`EX2_XLEN-1:0]       srIn,		// Current status register
	output logic [`EX2_GPR_ID_W-1:0]   selIdRn,
	output logic [`EX2_XLEN-1:0]       selValRn,
	output logic [`EX2_CR_ID_W-1:0]    selIdCn,
	output logic [`EX2_XLEN-1:0]       selValCn,
	output logic [`EX2_XLEN-1:0]       selSr
);

	logic [1:0]              aluTag;		// New S/T from ALU
	logic [1:0]              krrTag;		// Keyring validity tag
	logic [`EX2_XLEN-1:0]    aluVal;
	logic [`EX2_XLEN-1:0]    krrVal;
	logic                    doAluSr;		// ALU status goes to SR

	assign aluVal = aluRes[`EX2_XLEN-1:0];
	assign aluTag = aluRes[`EX2_TAGGED_W-1:`EX2_XLEN];
	assign krrVal = krreRes[`EX2_XLEN-1:0];
	assign krrTag = krreRes[`EX2_TAGGED_W-1:`EX2_XLEN];

	always_comb begin
		// Pass EX1 results through unless the command claims the port
		selIdRn  = regIdRn1;
		selValRn = regValRn1;
		selIdCn  = regIdCn1;
		selValCn = regValCn1;
		selSr    = srIn;
		doAluSr  = 1'b0;

		case (cmd)
			ex2Pkg::ucAlu3, ex2Pkg::ucUnary, ex2Pkg::ucAluw3: begin
				selIdRn  = regIdRm;
				selValRn = aluVal;
				doAluSr  = 1'b1;
			end

			ex2Pkg::ucAluCmp: begin
				doAluSr = 1'b1;		// Status only, no GPR write
			end

			ex2Pkg::ucMul3: begin
				selIdRn  = regIdRm;
				selValRn = mulRes;
			end

			ex2Pkg::ucMulw3: begin
				selIdRn  = regIdRm;
				selValRn = mulwRes;
			end

			ex2Pkg::ucFpu3: begin
				selIdRn  = regIdRm;
				selValRn = fpuRes;
			end

			ex2Pkg::ucFcmp: begin
				selSr[0] = fpuSrT;		// T bit from FPU compare
			end

			ex2Pkg::ucMovMr: begin
				// Load result, valid once the L1 reports ok
				selIdRn  = regIdRm;
				selValRn = memData;
			end

			ex2Pkg::ucMovRm: begin
				// Store has nothing to write back here
			end

			ex2Pkg::ucOpIxt: begin
				case (ixt)
					ex2Pkg::ixLdeEnc: begin
						selIdRn  = `EX2_GR_DLR;	// Encoded key always lands in DLR
						selValRn = krrVal;
					end

					ex2Pkg::ixLdeKrr: begin
						if (krrTag == 2'b10) begin		// Only a valid key reaches KRR
							selIdCn  = `EX2_CR_KRR;
							selValCn = krrVal;
						end
					end

					default: begin
						// sleep and nop only affect hold
					end
				endcase
			end

			default: begin
				// nop, bra and unknown ops forward EX1
			end
		endcase

		if (doAluSr)
			selSr[1:0] = aluTag;	// S and T from ALU tag
	end

endmodule

/* hdl/ex2HoldCtrl.sv */
/* EX2 stall logic: fixed hold counts for long ops, L1 status stall on
   memory ops, and a sticky memory fault flag. */

`include "ex2_params.svh"

module ex2HoldCtrl (
	input  logic             clock,
	input  logic             rst,
	input  ex2Pkg::uCmd      cmd,		// Effective command
	input  ex2Pkg::ixtOp     ixt,
	input  ex2Pkg::memStatus memStatus,	// From the L1 data port
	output logic             exHold,		// Stall the pipeline this cycle
	output logic             memFault		// Sticky until reset
);

	logic [`EX2_HOLD_W-1:0] holdCount;	// Cycles already held
	logic [`EX2_HOLD_W-1:0] needCount;	// Cycles this op must hold
	logic                   isMemOp;
	logic                   memBusy;	// L1 not ready
	logic                   memSawFault;

	// Required hold length per command
	always_comb begin
		needCount = '0;
		isMemOp   = 1'b0;
		case (cmd)
			ex2Pkg::ucOpIxt: begin
				if (ixt == ex2Pkg::ixSleep)
					needCount = `EX2_HOLD_SLEEP;
			end
			ex2Pkg::ucMul3: begin
				needCount = `EX2_HOLD_MUL;
			end
			ex2Pkg::ucMovMr, ex2Pkg::ucMovRm: begin
				needCount = `EX2_HOLD_MEM;	// First cycle always waits
				isMemOp   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign memBusy     = isMemOp && (memStatus != ex2Pkg::msOk);
	assign memSawFault = isMemOp && (memStatus == ex2Pkg::msFault);

	// Counter short of target, or memory still busy
	assign exHold = (holdCount < needCount) || memBusy;

	always_ff @(posedge clock) begin
		if (rst) begin
			holdCount <= '0;
		end else if (exHold) begin
			if (holdCount != `EX2_HOLD_MAX)
				holdCount <= holdCount + 1'b1;	// Saturating
		end else begin
			holdCount <= '0;		// Op done, ready for next
		end
	end

	always_ff @(posedge clock) begin
		if (rst)
			memFault <= 1'b0;
		else if (memSawFault)
			memFault <= 1'b1;
	end

endmodule

/* hdl/ex2Stage.sv */
/* EX2 pipeline stage top: predicates the micro-op, runs writeback selection
   and hold control side by side, and masks the writes while stalled. */

`include "ex2_params.svh"

module ex2Stage (
	input  logic                       clock,
	input  logic                       rst,
	input  logic [`EX2_UCMD_W-1:0]     opUCmd,		// Predicate in top two bits
	input  logic [`EX2_UIXT_W-1:0]     opUIxt,
	input  logic                       opBraFlush,	// Branch flush kills the op
	input  logic                       lastSrT,		// T bit seen by predication
	input  logic [`EX2_GPR_ID_W-1:0]   regIdRm,
	input  logic [`EX2_GPR_ID_W-1:0]   regIdRn1,
	input  logic [`EX2_XLEN-1:0]       regValRn1,
	input  logic [`EX2_CR_ID_W-1:0]    regIdCn1,
	input  logic [`EX2_XLEN-1:0]       regValCn1,
	input  logic [`EX2_TAGGED_W-1:0]   aluRes,
	input  logic [`EX2_XLEN-1:0]       mulRes,
	input  logic [`EX2_XLEN-1:0]       mulwRes,
	input  logic [`EX2_TAGGED_W-1:0]   krreRes,
	input  logic [`EX2_XLEN-1:0]       fpuRes,
	input  logic                       fpuSrT,
	input  logic [`EX2_XLEN-1:0]       memData,
	input  ex2Pkg::memStatus           memStatus,
	input  logic [`EX2_XLEN-1:0]       srIn,
	output logic [`EX2_GPR_ID_W-1:0]   regIdRn2,
	output logic [`EX2_XLEN-1:0]       regValRn2,
	output logic [`EX2_CR_ID_W-1:0]    regIdCn2,
	output logic [`EX2_XLEN-1:0]       regValCn2,
	output logic [`EX2_XLEN-1:0]       srOut,
	output logic                       exHold,
	output logic                       memFault
);

	ex2Pkg::predMode              predSel;
	ex2Pkg::uCmd                  effCmd;	// nop unless enabled
	ex2Pkg::ixtOp                 effIxt;
	logic                         opEnable;
	logic [`EX2_GPR_ID_W-1:0]     selIdRn;
	logic [`EX2_CR_ID_W-1:0]      selIdCn;
	logic [`EX2_XLEN-1:0]         selSr;

	assign predSel = ex2Pkg::predMode'(opUCmd[`EX2_UCMD_W-1 -: 2]);
	assign effIxt  = ex2Pkg::ixtOp'(opUIxt);

	always_comb begin
		case (predSel)
			ex2Pkg::predAlways:  opEnable = 1'b1;
			ex2Pkg::predNever:   opEnable = 1'b0;
			ex2Pkg::predIfTrue:  opEnable = lastSrT;
			ex2Pkg::predIfFalse: opEnable = !lastSrT;
			default:             opEnable = 1'b0;
		endcase
		// Flush wins over any predicate
		if (opEnable && !opBraFlush)
			effCmd = ex2Pkg::uCmd'(opUCmd[`EX2_UCMD_W-3:0]);
		else
			effCmd = ex2Pkg::ucNop;
	end

	ex2Writeback u_ex2Writeback (
		.cmd       (effCmd),
		.ixt       (effIxt),
		.regIdRm   (regIdRm),
		.regIdRn1  (regIdRn1),
		.regValRn1 (regValRn1),
		.regIdCn1  (regIdCn1),
		.regValCn1 (regValCn1),
		.aluRes    (aluRes),
		.mulRes    (mulRes),
		.mulwRes   (mulwRes),
		.krreRes   (krreRes),
		.fpuRes    (fpuRes),
		.fpuSrT    (fpuSrT),
		.memData   (memData),
		.srIn      (srIn),
		.selIdRn   (selIdRn),
		.selValRn  (regValRn2),		// Value passes, ID gated below
		.selIdCn   (selIdCn),
		.selValCn  (regValCn2),
		.selSr     (selSr)
	);

	ex2HoldCtrl u_ex2HoldCtrl (
		.clock     (clock),
		.rst       (rst),
		.cmd       (effCmd),
		.ixt       (effIxt),
		.memStatus (memStatus),
		.exHold    (exHold),
		.memFault  (memFault)
	);

	// No register or status write while stalled
	assign regIdRn2 = exHold ? `EX2_GR_NONE : selIdRn;
	assign regIdCn2 = exHold ? `EX2_CR_NONE : selIdCn;
	assign srOut    = exHold ? srIn : selSr;

endmodule

/* tb/ex2_properties.sv */
/* Concurrent checks on the EX2 stage ports, bound into every ex2Stage.
   failCount lets the testbench see a failure. */

`include "ex2_params.svh"

module ex2Properties (
	input logic                       clock,
	input logic                       rst,
	input logic [`EX2_UCMD_W-1:0]     opUCmd,
	input logic [`EX2_UIXT_W-1:0]     opUIxt,
	input logic                       opBraFlush,
	input logic                       lastSrT,
	input logic [`EX2_GPR_ID_W-1:0]   regIdRm,
	input logic [`EX2_GPR_ID_W-1:0]   regIdRn1,
	input logic [`EX2_XLEN-1:0]       regValRn1,
	input logic [`EX2_CR_ID_W-1:0]    regIdCn1,
	input logic [`EX2_XLEN-1:0]       regValCn1,
	input logic [`EX2_TAGGED_W-1:0]   aluRes,
	input logic [`EX2_XLEN-1:0]       mulRes,
	input logic [`EX2_TAGGED_W-1:0]   krreRes,
	input logic                       fpuSrT,
	input logic [`EX2_XLEN-1:0]       memData,
	input logic [1:0]                 memStatus,
	input logic [`EX2_XLEN-1:0]       srIn,
	input logic [`EX2_GPR_ID_W-1:0]   regIdRn2,
	input logic [`EX2_XLEN-1:0]       regValRn2,
	input logic [`EX2_CR_ID_W-1:0]    regIdCn2,
	input logic [`EX2_XLEN-1:0]       regValCn2,
	input logic [`EX2_XLEN-1:0]       srOut,
	input logic                       exHold,
	input logic                       memFault
);

	int         failCount = 0;
	logic [1:0] pred;
	logic [5:0] cmd;
	logic       en;	// Op survives predicate and flush
	logic       isMul, isLoad, isMem, isKrr, isEnc;

	assign pred   = opUCmd[7:6];
	assign cmd    = opUCmd[5:0];
	assign en     = !opBraFlush && (pred == 2'b00 || (pred == 2'b10 && lastSrT)
			|| (pred == 2'b11 && !lastSrT));
	assign isMul  = en && cmd == ex2Pkg::ucMul3;
	assign isLoad = en && cmd == ex2Pkg::ucMovMr;
	assign isMem  = isLoad || (en && cmd == ex2Pkg::ucMovRm);
	assign isKrr  = en && cmd == ex2Pkg::ucOpIxt && opUIxt == ex2Pkg::ixLdeKrr;
	assign isEnc  = en && cmd == ex2Pkg::ucOpIxt && opUIxt == ex2Pkg::ixLdeEnc;

	// Disabled op forwards EX1 untouched
	aDisabled: assert property (@(posedge clock) disable iff (rst)
		!en |-> !exHold && regIdRn2 == regIdRn1 && regValRn2 == regValRn1
			&& regIdCn2 == regIdCn1 && regValCn2 == regValCn1 && srOut == srIn)
		else begin failCount++; $error("[ERROR] %0t disabled op changed outputs", $time); end

	aAlu: assert property (@(posedge clock) disable iff (rst)
		en && cmd == ex2Pkg::ucAlu3 |-> regIdRn2 == regIdRm && regValRn2 == aluRes[63:0]
			&& srOut == {srIn[63:2], aluRes[65:64]})
		else begin failCount++; $error("[ERROR] %0t alu3 writeback wrong", $time); end

	aCmp: assert property (@(posedge clock) disable iff (rst)
		en && cmd == ex2Pkg::ucAluCmp |-> regIdRn2 == regIdRn1 && regValRn2 == regValRn1
			&& regIdCn2 == regIdCn1 && regValCn2 == regValCn1
			&& srOut == {srIn[63:2], aluRes[65:64]})
		else begin failCount++; $error("[ERROR] %0t aluCmp result wrong", $time); end

	// T bit from the FPU compare, no register write
	aFcmp: assert property (@(posedge clock) disable iff (rst)
		en && cmd == ex2Pkg::ucFcmp |-> regIdRn2 == regIdRn1 && regIdCn2 == regIdCn1
			&& srOut == {srIn[63:1], fpuSrT})
		else begin failCount++; $error("[ERROR] %0t fcmp status update wrong", $time); end

	// Three held cycles, released on the fourth
	aMul: assert property (@(posedge clock) disable iff (rst)
		isMul && !$past(exHold) |-> exHold ##1 exHold ##1 exHold
			##1 (!exHold && regIdRn2 == regIdRm && regValRn2 == mulRes))
		else begin failCount++; $error("[ERROR] %0t mul3 stall length or result wrong", $time); end

	aMask: assert property (@(posedge clock) disable iff (rst)
		exHold |-> regIdRn2 == `EX2_GR_NONE && regIdCn2 == `EX2_CR_NONE && srOut == srIn)
		else begin failCount++; $error("[ERROR] %0t write not masked during stall", $time); end

	aMemFirst: assert property (@(posedge clock) disable iff (rst)
		isMem && !$past(exHold) |-> exHold)
		else begin failCount++; $error("[ERROR] %0t memory op did not wait first cycle", $time); end

	aMemBusy: assert property (@(posedge clock) disable iff (rst)
		isMem && memStatus != ex2Pkg::msOk |-> exHold)
		else begin failCount++; $error("[ERROR] %0t memory op ran while L1 busy", $time); end

	aLoad: assert property (@(posedge clock) disable iff (rst)
		isLoad && !exHold |-> regIdRn2 == regIdRm && regValRn2 == memData)
		else begin failCount++; $error("[ERROR] %0t load data not written", $time); end

	aFaultSet: assert property (@(posedge clock) disable iff (rst)
		isMem && memStatus == ex2Pkg::msFault |=> memFault)
		else begin failCount++; $error("[ERROR] %0t fault flag not set", $time); end

	aFaultStay: assert property (@(posedge clock) disable iff (rst)
		memFault |=> memFault)
		else begin failCount++; $error("[ERROR] %0t fault flag cleared without reset", $time); end

	aKrr: assert property (@(posedge clock) disable iff (rst)
		isKrr |-> (krreRes[65:64] == 2'b10) ? (regIdCn2 == `EX2_CR_KRR
			&& regValCn2 == krreRes[63:0]) : (regIdCn2 == regIdCn1))
		else begin failCount++; $error("[ERROR] %0t ldeKrr tag gating wrong", $time); end

	aEnc: assert property (@(posedge clock) disable iff (rst)
		isEnc |-> regIdRn2 == `EX2_GR_DLR && regValRn2 == krreRes[63:0])
		else begin failCount++; $error("[ERROR] %0t ldeEnc did not write DLR", $time); end

endmodule

bind ex2Stage ex2Properties u_ex2Properties (
	.clock, .rst, .opUCmd, .opUIxt, .opBraFlush, .lastSrT, .regIdRm, .regIdRn1,
	.regValRn1, .regIdCn1, .regValCn1, .aluRes, .mulRes, .krreRes, .fpuSrT,
	.memData, .memStatus, .srIn, .regIdRn2, .regValRn2, .regIdCn2, .regValCn2,
	.srOut, .exHold, .memFault
);

/* tb/ex2Tb.sv */
/* Testbench for the EX2 stage: directed sequences then random ops, each held
   until exHold falls. Checking is done by the bound assertions. */

`include "ex2_params.svh"

module ex2Tb;

	localparam int CycleLimit = 200 * 20 + 500;	// Random ops times worst case, plus directed

	logic                       clock;
	logic                       rst;
	logic [`EX2_UCMD_W-1:0]     opUCmd;
	logic [`EX2_UIXT_W-1:0]     opUIxt;
	logic                       opBraFlush;
	logic                       lastSrT;
	logic [`EX2_GPR_ID_W-1:0]   regIdRm;
	logic [`EX2_GPR_ID_W-1:0]   regIdRn1;
	logic [`EX2_XLEN-1:0]       regValRn1;
	logic [`EX2_CR_ID_W-1:0]    regIdCn1;
	logic [`EX2_XLEN-1:0]       regValCn1;
	logic [`EX2_TAGGED_W-1:0]   aluRes;
	logic [`EX2_XLEN-1:0]       mulRes;
	logic [`EX2_XLEN-1:0]       mulwRes;
	logic [`EX2_TAGGED_W-1:0]   krreRes;
	logic [`EX2_XLEN-1:0]       fpuRes;
	logic                       fpuSrT;
	logic [`EX2_XLEN-1:0]       memData;
	ex2Pkg::memStatus           memStatus;
	logic [`EX2_XLEN-1:0]       srIn;
	logic [`EX2_GPR_ID_W-1:0]   regIdRn2;
	logic [`EX2_XLEN-1:0]       regValRn2;
	logic [`EX2_CR_ID_W-1:0]    regIdCn2;
	logic [`EX2_XLEN-1:0]       regValCn2;
	logic [`EX2_XLEN-1:0]       srOut;
	logic                       exHold;
	logic                       memFault;
	integer                     seed = 32'h18ff_0161;
	int                         cycles = 0;

	ex2Stage u_ex2Stage (
		.clock, .rst, .opUCmd, .opUIxt, .opBraFlush, .lastSrT, .regIdRm,
		.regIdRn1, .regValRn1, .regIdCn1, .regValCn1, .aluRes, .mulRes,
		.mulwRes, .krreRes, .fpuRes, .fpuSrT, .memData, .memStatus, .srIn,
		.regIdRn2, .regValRn2, .regIdCn2, .regValCn2, .srOut, .exHold, .memFault
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = !clock;	// Period 4
	end

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// Drive one op, keep it steady until the stage stops holding
	task automatic doOp(input logic [1:0] pred, input logic [5:0] cmd,
			input logic [5:0] ixt, input logic tBit, input logic flush,
			input int memWait, input logic faultOnWait, input logic [1:0] krrTag);
		int n;
		logic [63:0] r;
		n = 0;
		r = rand64();
		opUCmd     <= {pred, cmd};
		opUIxt     <= ixt;
		lastSrT    <= tBit;
		opBraFlush <= flush;
		regIdRm    <= r[5:0];
		regIdRn1   <= r[11:6];
		regIdCn1   <= r[16:12];
		fpuSrT     <= r[17];
		aluRes     <= {r[19:18], rand64()};
		krreRes    <= {krrTag, rand64()};
		regValRn1  <= rand64();
		regValCn1  <= rand64();
		mulRes     <= rand64();
		mulwRes    <= rand64();
		fpuRes     <= rand64();
		memData    <= rand64();
		srIn       <= rand64();
		if (memWait == 0)
			memStatus <= ex2Pkg::msOk;
		else if (faultOnWait)
			memStatus <= ex2Pkg::msFault;
		else
			memStatus <= ex2Pkg::msHold;
		do begin
			@(posedge clock);
			n++;
			if (n >= memWait)
				memStatus <= ex2Pkg::msOk;	// L1 finally answers
		end while (exHold);
	endtask

	// Timeout guard
	always @(posedge clock) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Finished with errors");
			$fatal(1, "Timeout after %0d cycles, stage never finished", cycles);
		end
	end

	// Stop at the first failed assertion
	always @(posedge clock) begin
		if (u_ex2Stage.u_ex2Properties.failCount != 0) begin
			$display("Finished with errors");
			$fatal(1, "Assertion failure detected");
		end
	end

	initial begin
		logic [63:0] r;
		rst = 1'b1;
		opUCmd = '0;
		opUIxt = '0;
		opBraFlush = 1'b0;
		lastSrT = 1'b0;
		regIdRm = '0;
		regIdRn1 = '0;
		regValRn1 = '0;
		regIdCn1 = '0;
		regValCn1 = '0;
		aluRes = '0;
		mulRes = '0;
		mulwRes = '0;
		krreRes = '0;
		fpuRes = '0;
		fpuSrT = 1'b0;
		memData = '0;
		memStatus = ex2Pkg::msOk;
		srIn = '0;
		repeat (16) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);

		// Disabled ops: never, false predicate, flush
		doOp(2'b01, ex2Pkg::ucAlu3, 6'd0, 1'b1, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b10, ex2Pkg::ucMul3, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b11, ex2Pkg::ucAlu3, 6'd0, 1'b1, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucMovMr, 6'd0, 1'b0, 1'b1, 0, 1'b0, 2'b00);
		// ALU, compare, FPU compare
		doOp(2'b00, ex2Pkg::ucAlu3, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b10, ex2Pkg::ucAlu3, 6'd0, 1'b1, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucAluCmp, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucFcmp, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		// Multi-cycle ops
		doOp(2'b00, ex2Pkg::ucMul3, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucMul3, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucOpIxt, ex2Pkg::ixSleep, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		// Loads and stores, with and without L1 hold
		doOp(2'b00, ex2Pkg::ucMovMr, 6'd0, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucMovMr, 6'd0, 1'b0, 1'b0, 4, 1'b0, 2'b00);
		doOp(2'b00, ex2Pkg::ucMovRm, 6'd0, 1'b0, 1'b0, 3, 1'b0, 2'b00);
		// Keyring, valid and invalid tags
		doOp(2'b00, ex2Pkg::ucOpIxt, ex2Pkg::ixLdeKrr, 1'b0, 1'b0, 0, 1'b0, 2'b10);
		doOp(2'b00, ex2Pkg::ucOpIxt, ex2Pkg::ixLdeKrr, 1'b0, 1'b0, 0, 1'b0, 2'b01);
		doOp(2'b00, ex2Pkg::ucOpIxt, ex2Pkg::ixLdeEnc, 1'b0, 1'b0, 0, 1'b0, 2'b00);
		// Fault goes sticky
		doOp(2'b00, ex2Pkg::ucMovMr, 6'd0, 1'b0, 1'b0, 2, 1'b1, 2'b00);

		repeat (200) begin
			r = rand64();
			doOp(r[1:0], r[7:2] % 6'd13, {4'b0, r[9:8]}, r[10], r[11] & r[12],
				int'(r[15:13]), r[16] & r[17], r[19:18]);
		end

		repeat (2) @(posedge clock);
		#1;	// Assertion actions of the last edge are done by now
		if (u_ex2Stage.u_ex2Properties.failCount == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "Assertion failure detected at end of run");
		end
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/ex2Pkg.sv
hdl/ex2Writeback.sv
hdl/ex2HoldCtrl.sv
hdl/ex2Stage.sv
tb/ex2_properties.sv
tb/ex2Tb.sv

/* run.sh */
#!/bin/sh
# Build and run the EX2 stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module ex2Tb \
	-Mdir obj_dir \
	-f sources.f

# The simulator exits nonzero on failure; the log decides the result
./obj_dir/Vex2Tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
